// ==== machine_timer.sv ====
// ============================================================
// Machine timer. Only word stores are honoured, smaller widths
// to the timer window are silently ignored
// ============================================================
`timescale 1ns/1ps
`include "store_cfg.svh"

module machine_timer
    import store_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         timer_write_i,
    input  store_entry_t timer_entry_i,
    output logic         timer_irq_o
);

    logic [63:0] mtime_q, mtimecmp_q;
    data_word_t  offset;
    logic [1:0]  word_sel;
    logic        word_write;

    // Word index inside the window
    assign offset     = timer_entry_i.address - `TIMER_START;
    assign word_sel   = offset[3:2];
    assign word_write = timer_write_i && (timer_entry_i.width == WORD);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_o <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;

            // A write replaces the addressed half and overrides the increment
            if (word_write) begin
                case (word_sel)
                    2'd0:    mtime_q[31:0]     <= timer_entry_i.data;
                    2'd1:    mtime_q[63:32]    <= timer_entry_i.data;
                    2'd2:    mtimecmp_q[31:0]  <= timer_entry_i.data;
                    default: mtimecmp_q[63:32] <= timer_entry_i.data;
                endcase
            end

            // Compared against the registered values, so the interrupt
            // trails a compare update by one cycle
            timer_irq_o <= mtime_q >= mtimecmp_q;
        end
    end

endmodule : machine_timer

// ==== run_sim.sh ====
#!/bin/sh
# Builds the store path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_store_path -f vlog.f -o sim_store_path
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_store_path > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

// ==== store_buffer.sv ====
// ============================================================
// In-order store buffer. Forwarding compares word addresses only
// and returns the whole stored word, no byte merging is done
// ============================================================
`timescale 1ns/1ps
`include "store_cfg.svh"

module store_buffer
    import store_pkg::*;
#(
    parameter int DEPTH = `STORE_BUFFER_SIZE
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Push side, driven by the store unit
    input  logic         push_i,
    input  store_entry_t push_entry_i,
    output logic         full_o,
    output logic         empty_o,

    // Commits the oldest speculative entry
    input  logic         validate_i,

    // Drain side towards the memory controller
    output mem_store_t   mem_store_o,
    input  logic         mem_done_i,

    // Store to load forwarding
    input  logic [29:0]  foward_address_i,
    output data_word_t   foward_data_o,
    output logic         foward_match_o
);

    localparam int PTR_W = $clog2(DEPTH);

//============================================================
//      POINTERS
//============================================================

    // Pointers carry one extra wrap bit to tell full from empty
    // head <= vld <= tail, entries in [head, vld) are committed
    logic [PTR_W:0] head_q, vld_q, tail_q;
    logic [PTR_W:0] count;
    logic           push_ok, validate_ok, drain_valid, pop_ok;

    assign count   = tail_q - head_q;
    assign empty_o = head_q == tail_q;
    assign full_o  = (head_q[PTR_W] != tail_q[PTR_W])
                   && (head_q[PTR_W-1:0] == tail_q[PTR_W-1:0]);

    // A flush kills the push of the same cycle, it is speculative too
    assign push_ok     = push_i && !full_o && !flush_i;
    assign validate_ok = validate_i && (vld_q != tail_q);
    assign drain_valid = head_q != vld_q;
    assign pop_ok      = drain_valid && mem_done_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            vld_q  <= '0;
            tail_q <= '0;
        end else begin
            if (pop_ok) begin
                head_q <= head_q + 1'b1;
            end

            if (validate_ok) begin
                vld_q <= vld_q + 1'b1;
            end

            // Flush drops every speculative entry, a validate in the
            // same cycle still commits its entry first
            if (flush_i) begin
                tail_q <= vld_q + {{PTR_W{1'b0}}, validate_ok};
            end else if (push_ok) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

//============================================================
//      STORAGE AND DRAIN
//============================================================

    store_entry_t entries_q [DEPTH];
    store_entry_t head_entry;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            entries_q[tail_q[PTR_W-1:0]] <= push_entry_i;
        end
    end

    // Lanes touched by a store of the given size at the given offset
    function automatic logic [3:0] byte_enable(input store_width_t width,
                                               input logic [1:0] offset);
        logic [3:0] mask;
        case (width)
            BYTE:    mask = 4'b0001 << offset;
            HALF:    mask = offset[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    assign head_entry = entries_q[head_q[PTR_W-1:0]];

    // The head entry is held stable until the controller answers
    always_comb begin
        mem_store_o.request     = drain_valid;
        mem_store_o.entry       = head_entry;
        mem_store_o.byte_enable = byte_enable(head_entry.width, head_entry.address[1:0]);
    end

//============================================================
//      FORWARDING
//============================================================

    // Walk from the oldest live entry to the youngest, every hit
    // overwrites the previous one so the youngest match wins
    always_comb begin : forward_search
        logic [PTR_W-1:0] idx;
        foward_data_o  = '0;
        foward_match_o = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head_q[PTR_W-1:0] + PTR_W'(i);
            if ((i < int'(count)) && (entries_q[idx].address[31:2] == foward_address_i)) begin
                foward_data_o  = entries_q[idx].data;
                foward_match_o = 1'b1;
            end
        end
    end

endmodule : store_buffer

// ==== store_cases.txt ====
# op address data width expected, all hex; width 0 byte, 1 half, 2 word
# op 0 push, 1 validate, 2 drain, 3 forward, 4 blocked, 5 wait_valid, 6 illegal, 7 timer, 8 flush, 9 empty
# Program order drain, expected holds the byte enable
0 00002000 11112222 2 1
0 00002006 0000abcd 1 1
0 00002003 000000ef 0 1
0 00002009 00000042 0 1
1 00000000 00000000 0 0
1 00000000 00000000 0 0
1 00000000 00000000 0 0
1 00000000 00000000 0 0
2 00002000 11112222 2 f
2 00002006 0000abcd 1 c
2 00002003 000000ef 0 8
2 00002009 00000042 0 2
9 00000000 00000000 0 1
# Youngest matching word is forwarded
0 00003000 aaaa0001 2 1
0 00003002 0000bbbb 1 1
3 00003000 0000bbbb 0 1
3 00003100 00000000 0 0
8 00000000 00000000 0 0
9 00000000 00000000 0 1
# Full buffer holds the ninth store
0 00004000 40000000 2 1
0 00004004 40000004 2 1
0 00004008 40000008 2 1
0 0000400c 4000000c 2 1
0 00004010 40000010 2 1
0 00004014 40000014 2 1
0 00004018 40000018 2 1
0 0000401c 4000001c 2 1
4 00004040 cafe0040 2 0
3 00004040 cafe0040 0 1
1 00000000 00000000 0 0
2 00004000 40000000 2 f
5 00000000 00000000 0 0
8 00000000 00000000 0 0
9 00000000 00000000 0 1
# Flush keeps the one validated store
0 00005000 50000000 2 1
0 00005004 50000004 2 1
0 00005008 50000008 2 1
1 00000000 00000000 0 0
8 00000000 00000000 0 0
2 00005000 50000000 2 f
9 00000000 00000000 0 1
# Boot region store is dropped
6 00000800 deadbeef 2 1
9 00000000 00000000 0 1
# Timer compare, expected holds timer_irq_o
7 0000f008 00000000 2 0
7 0000f00c 00000000 2 1
7 0000f008 ffffffff 2 0
7 0000f00c ffffffff 2 0

// ==== store_cfg.svh ====
// ============================================================
// Build time configuration of the store path. The buffer depth
// must be a power of two, at least 2. Timer words must be aligned
// ============================================================

`ifndef STORE_CFG_SVH
`define STORE_CFG_SVH

// Number of entries in the store buffer
`define STORE_BUFFER_SIZE 8

// Machine timer window, four words: mtime low, mtime high,
// mtimecmp low and mtimecmp high, in that order
`define TIMER_START 32'h0000_F000
`define TIMER_END   32'h0000_F00F

// Everything below this address belongs to the boot region
`define BOOT_END 32'h0000_1000

`endif

// ==== store_path.sv ====
// ============================================================
// Store path top level: store unit with its buffer plus the
// memory mapped machine timer
// ============================================================
`timescale 1ns/1ps

module store_path
    import store_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,

    // Issue stage
    input  logic         valid_operation_i,
    input  data_word_t   store_data_i,
    input  data_word_t   store_address_i,
    input  store_width_t width_i,
    input  logic         data_accepted_i,

    // Core control
    input  logic         validate_i,
    input  logic         flush_i,

    // Forwarding
    input  logic [29:0]  foward_address_i,
    output data_word_t   foward_data_o,
    output logic         foward_match_o,

    // Memory controller
    output mem_store_t   mem_store_o,
    input  logic         mem_done_i,

    // Status
    output logic         idle_o,
    output logic         data_valid_o,
    output logic         illegal_access_o,
    output logic         buffer_empty_o,
    output logic         timer_irq_o
);

    logic         timer_write;
    store_entry_t timer_entry;

    store_unit u_store_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .valid_operation_i (valid_operation_i),
        .store_data_i      (store_data_i),
        .store_address_i   (store_address_i),
        .width_i           (width_i),
        .data_accepted_i   (data_accepted_i),
        .validate_i        (validate_i),
        .mem_store_o       (mem_store_o),
        .mem_done_i        (mem_done_i),
        .foward_address_i  (foward_address_i),
        .foward_data_o     (foward_data_o),
        .foward_match_o    (foward_match_o),
        .buffer_empty_o    (buffer_empty_o),
        .timer_write_o     (timer_write),
        .timer_entry_o     (timer_entry),
        .idle_o            (idle_o),
        .illegal_access_o  (illegal_access_o),
        .data_valid_o      (data_valid_o)
    );

    machine_timer u_machine_timer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .timer_write_i (timer_write),
        .timer_entry_i (timer_entry),
        .timer_irq_o   (timer_irq_o)
    );

endmodule : store_path

// ==== store_pkg.sv ====
// ============================================================
// Types shared by the store path. Addresses are byte addresses
// ============================================================

package store_pkg;

    // Generic data or address word of the core
    typedef logic [31:0] data_word_t;

    // Store size, taken from the funct3 field of the store opcode
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } store_width_t;

    // One pending store as it sits in the buffer
    // The data is kept unshifted, the byte enable tells the
    // memory controller which lanes are meaningful
    typedef struct packed {
        data_word_t   data;
        data_word_t   address;
        store_width_t width;
    } store_entry_t;

    // Channel towards the memory controller
    typedef struct packed {
        // High while a validated entry waits at the head
        logic         request;

        // Entry at the head of the buffer
        store_entry_t entry;

        // One bit per byte lane, LSB is the lowest address
        logic [3:0]   byte_enable;
    } mem_store_t;

endpackage : store_pkg

// ==== store_unit.sv ====
// ============================================================
// Store unit FSM. Stores to the boot region are dropped and flagged,
// timer stores bypass the buffer and complete in the same cycle
// ============================================================
`timescale 1ns/1ps
`include "store_cfg.svh"

module store_unit
    import store_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Issue stage
    input  logic         valid_operation_i,
    input  data_word_t   store_data_i,
    input  data_word_t   store_address_i,
    input  store_width_t width_i,
    input  logic         data_accepted_i,

    // Buffer control and memory channel
    input  logic         validate_i,
    output mem_store_t   mem_store_o,
    input  logic         mem_done_i,

    // Forwarding towards the load unit
    input  logic [29:0]  foward_address_i,
    output data_word_t   foward_data_o,
    output logic         foward_match_o,

    output logic         buffer_empty_o,

    // Memory mapped timer write port
    output logic         timer_write_o,
    output store_entry_t timer_entry_o,

    // Status
    output logic         idle_o,
    output logic         illegal_access_o,
    output logic         data_valid_o
);

//============================================================
//      ADDRESS DECODE AND SAMPLING
//============================================================

    logic         timer_access, accessable;
    store_entry_t input_entry, store_q;
    logic         illegal_q;

    assign input_entry   = '{data: store_data_i, address: store_address_i, width: width_i};
    assign timer_access  = (store_address_i >= `TIMER_START) && (store_address_i <= `TIMER_END);
    assign accessable    = store_address_i >= `BOOT_END;
    assign timer_entry_o = input_entry;

    typedef enum logic [1:0] {IDLE, WAIT_BUFFER, WAIT_ACCEPT} state_t;
    state_t state_q, state_d;

    // Operands are captured when the store is taken so the
    // retry in WAIT_BUFFER does not depend on the issue stage
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && valid_operation_i) begin
            store_q <= input_entry;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            illegal_q <= 1'b0;
        end else if ((state_q == IDLE) && valid_operation_i) begin
            illegal_q <= !timer_access && !accessable;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

//============================================================
//      FSM
//============================================================

    logic         push, buffer_full, fsm_match;
    store_entry_t push_entry;

    always_comb begin
        state_d       = state_q;
        push          = 1'b0;
        push_entry    = input_entry;
        idle_o        = 1'b0;
        data_valid_o  = 1'b0;
        timer_write_o = 1'b0;
        fsm_match     = 1'b0;

        case (state_q)
            IDLE: begin
                idle_o = 1'b1;
                if (valid_operation_i) begin
                    if (timer_access) begin
                        timer_write_o = 1'b1;
                    end else if (!accessable) begin
                        state_d = WAIT_ACCEPT;
                    end else if (buffer_full) begin
                        state_d = WAIT_BUFFER;
                    end else begin
                        push = 1'b1;
                        // Busy for one cycle while the result is not yet taken
                        if (!data_accepted_i) begin
                            state_d = WAIT_ACCEPT;
                            idle_o  = 1'b0;
                        end
                    end
                end
            end

            WAIT_BUFFER: begin
                // Retry every cycle until a slot frees up
                push       = !buffer_full;
                push_entry = store_q;
                fsm_match  = foward_address_i == store_q.address[31:2];
                if (!buffer_full) begin
                    if (data_accepted_i) begin
                        state_d      = IDLE;
                        idle_o       = 1'b1;
                        data_valid_o = 1'b1;
                    end else begin
                        state_d = WAIT_ACCEPT;
                    end
                end
            end

            WAIT_ACCEPT: begin
                // Idle is raised early so the scheduler can issue ahead
                idle_o       = 1'b1;
                data_valid_o = 1'b1;
                if (data_accepted_i) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    assign illegal_access_o = illegal_q && (state_q == WAIT_ACCEPT);

//============================================================
//      BUFFER AND FORWARDING
//============================================================

    data_word_t buffer_foward_data;
    logic       buffer_match;

    store_buffer #(
        .DEPTH (`STORE_BUFFER_SIZE)
    ) u_store_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .push_i           (push),
        .push_entry_i     (push_entry),
        .full_o           (buffer_full),
        .empty_o          (buffer_empty_o),
        .validate_i       (validate_i),
        .mem_store_o      (mem_store_o),
        .mem_done_i       (mem_done_i),
        .foward_address_i (foward_address_i),
        .foward_data_o    (buffer_foward_data),
        .foward_match_o   (buffer_match)
    );

    // The waiting store is younger than anything in the buffer
    assign foward_data_o  = fsm_match ? store_q.data : buffer_foward_data;
    assign foward_match_o = fsm_match || buffer_match;

endmodule : store_unit

// ==== tb_store_path.sv ====
// ============================================================
// Self-checking testbench for the store path. It must run from the
// project root, where store_cases.txt holds one operation per line
// ============================================================
`timescale 1ns/1ps

module tb_store_path
    import store_pkg::*;
();

    // Longest wait for any DUT response, in clock cycles
    localparam int TIMEOUT = 200;

    logic         clk_i;
    logic         rst_n_i;
    logic         valid_operation_i;
    data_word_t   store_data_i;
    data_word_t   store_address_i;
    store_width_t width_i;
    logic         data_accepted_i;
    logic         validate_i;
    logic         flush_i;
    logic [29:0]  foward_address_i;
    data_word_t   foward_data_o;
    logic         foward_match_o;
    mem_store_t   mem_store_o;
    logic         mem_done_i;
    logic         idle_o;
    logic         data_valid_o;
    logic         illegal_access_o;
    logic         buffer_empty_o;
    logic         timer_irq_o;

    int errors       = 0;
    int tests        = 0;
    int failed_tests = 0;
    bit timed_out    = 1'b0;

    store_path u_store_path (.*);

    // 4 ns clock
    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

//============================================================
//      HELPERS
//============================================================

    // Inputs change half a nanosecond after the rising edge,
    // outputs are sampled on the falling edge
    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic check_bit(input string test, input string sig, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b actual %b", test, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string test, input string sig, input data_word_t exp,
                              input data_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_store(input string test, input mem_store_t exp, input mem_store_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s mem_store_o: expected %h actual %h", test, exp, act);
            errors++;
        end
    endtask

    // Both waits return on a falling edge with the condition met
    task automatic wait_request(input string test);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!mem_store_o.request && n < TIMEOUT) begin
            next_cycle();
            @(negedge clk_i);
            n++;
        end
        if (!mem_store_o.request) begin
            $display("%s: no memory request came within %0d cycles", test, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_data_valid(input string test);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!data_valid_o && n < TIMEOUT) begin
            next_cycle();
            @(negedge clk_i);
            n++;
        end
        if (!data_valid_o) begin
            $display("%s: data_valid_o did not rise within %0d cycles", test, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0:    return "push";
            4'h1:    return "validate";
            4'h2:    return "drain";
            4'h3:    return "forward";
            4'h4:    return "blocked";
            4'h5:    return "wait_valid";
            4'h6:    return "illegal";
            4'h7:    return "timer";
            4'h8:    return "flush";
            4'h9:    return "empty";
            default: return "unknown";
        endcase
    endfunction

//============================================================
//      OPERATIONS
//============================================================

    // Every operation starts and ends on a drive point
    task automatic run_case(input string test, input logic [3:0] op, input data_word_t addr,
                            input data_word_t data, input logic [1:0] width,
                            input data_word_t expv);
        mem_store_t  exp_store;
        int unsigned delay;
        exp_store.request       = 1'b1;
        exp_store.entry.data    = data;
        exp_store.entry.address = addr;
        exp_store.entry.width   = store_width_t'(width);
        exp_store.byte_enable   = expv[3:0];
        store_address_i = addr;
        store_data_i    = data;
        width_i         = store_width_t'(width);
        case (op)
            4'h0: begin
                // Accepted in the issue cycle, so the FSM stays idle
                valid_operation_i = 1'b1;
                data_accepted_i   = 1'b1;
                @(negedge clk_i);
                check_bit(test, "idle_o", expv[0], idle_o);
                next_cycle();
                valid_operation_i = 1'b0;
                data_accepted_i   = 1'b0;
            end
            4'h1: begin
                validate_i = 1'b1;
                next_cycle();
                validate_i = 1'b0;
            end
            4'h2: begin
                wait_request(test);
                if (!timed_out) begin
                    check_store(test, exp_store, mem_store_o);
                    // Memory controller answers 1 to 4 cycles later
                    delay = 1 + ($urandom % 4);
                    repeat (delay) next_cycle();
                    mem_done_i = 1'b1;
                    @(negedge clk_i);
                    check_store(test, exp_store, mem_store_o);
                    // A store held by a full buffer cannot finish before the pop
                    check_bit(test, "data_valid_o", 1'b0, data_valid_o);
                    next_cycle();
                    mem_done_i = 1'b0;
                end
            end
            4'h3: begin
                foward_address_i = addr[31:2];
                @(negedge clk_i);
                check_bit(test, "foward_match_o", expv[0], foward_match_o);
                if (expv[0]) begin
                    check_word(test, "foward_data_o", data, foward_data_o);
                end
                next_cycle();
            end
            4'h4: begin
                // Left unaccepted so the FSM parks in the buffer wait
                valid_operation_i = 1'b1;
                next_cycle();
                valid_operation_i = 1'b0;
                @(negedge clk_i);
                check_bit(test, "idle_o", expv[0], idle_o);
                check_bit(test, "data_valid_o", 1'b0, data_valid_o);
                next_cycle();
            end
            4'h5: begin
                wait_data_valid(test);
                if (!timed_out) begin
                    check_bit(test, "illegal_access_o", expv[0], illegal_access_o);
                    next_cycle();
                    data_accepted_i = 1'b1;
                    next_cycle();
                    data_accepted_i = 0;
                end
            end
            4'h6: begin
                valid_operation_i = 1'b1;
                next_cycle();
                valid_operation_i = 1'b0;
                @(negedge clk_i);
                check_bit(test, "illegal_access_o", expv[0], illegal_access_o);
                check_bit(test, "data_valid_o", 1'b1, data_valid_o);
                next_cycle();
                data_accepted_i = 1'b1;
                next_cycle();
                data_accepted_i = 1'b0;
                @(negedge clk_i);
                check_bit(test, "illegal_access_o", 1'b0, illegal_access_o);
                check_bit(test, "data_valid_o", 1'b0, data_valid_o);
                next_cycle();
            end
            4'h7: begin
                // Compare register updates on the first edge, irq on the next
                valid_operation_i = 1'b1;
                @(negedge clk_i);
                check_bit(test, "idle_o", 1'b1, idle_o);
                next_cycle();
                valid_operation_i = 1'b0;
                next_cycle();
                @(negedge clk_i);
                check_bit(test, "timer_irq_o", expv[0], timer_irq_o);
                next_cycle();
            end
            4'h8: begin
                flush_i = 1'b1;
                next_cycle();
                flush_i = 1'b0;
            end
            4'h9: begin
                @(negedge clk_i);
                check_bit(test, "buffer_empty_o", expv[0], buffer_empty_o);
                check_bit(test, "mem_store_o.request", 1'b0, mem_store_o.request);
                next_cycle();
            end
            default: begin
                $display("%s: unknown operation %h in the cases file", test, op);
                errors++;
            end
        endcase
    endtask

//============================================================
//      MAIN SEQUENCE
//============================================================

    initial begin
        int         fd;
        int         line_no;
        int         errors_before;
        string      line;
        string      test;
        data_word_t f_op, f_addr, f_data, f_width, f_exp;
        void'($urandom(32'h72a0_7fe4));
        rst_n_i           = 1'b0;
        valid_operation_i = 1'b0;
        store_data_i      = '0;
        store_address_i   = '0;
        width_i           = WORD;
        data_accepted_i   = 1'b0;
        validate_i        = 1'b0;
        flush_i           = 1'b0;
        foward_address_i  = '0;
        mem_done_i        = 1'b0;
        repeat (8) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;

        // Values right after reset
        @(negedge clk_i);
        errors_before = errors;
        check_bit("reset", "mem_store_o.request", 1'b0, mem_store_o.request);
        check_bit("reset", "data_valid_o", 1'b0, data_valid_o);
        check_bit("reset", "illegal_access_o", 1'b0, illegal_access_o);
        check_bit("reset", "timer_irq_o", 1'b0, timer_irq_o);
        check_bit("reset", "idle_o", 1'b1, idle_o);
        check_bit("reset", "buffer_empty_o", 1'b1, buffer_empty_o);
        tests++;
        if (errors != errors_before) begin
            failed_tests++;
            $display("FAIL reset");
        end else begin
            $display("PASS reset");
        end
        next_cycle();

        fd = $fopen("store_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open store_cases.txt, the run must start in the project root");
            errors++;
        end else begin
            line_no = 0;
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                // Comment and blank lines do not yield five fields
                if ($sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_width, f_exp) == 5) begin
                    test          = $sformatf("%s_line%0d", op_name(f_op[3:0]), line_no);
                    errors_before = errors;
                    run_case(test, f_op[3:0], f_addr, f_data, f_width[1:0], f_exp);
                    tests++;
                    if (errors != errors_before || timed_out) begin
                        failed_tests++;
                        $display("FAIL %s", test);
                    end else begin
                        $display("PASS %s", test);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d tests failed, %0d checks failed",
                 tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_store_path

// ==== vlog.f ====
+incdir+.
store_pkg.sv
store_buffer.sv
machine_timer.sv
store_unit.sv
store_path.sv
tb_store_path.sv
